// ==== Makefile ====
TOP := pet_bus_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== bench/pet_bus_tb.sv ====
`timescale 1ns/1ps
`include "pet_defs.svh"

module pet_bus_tb;
    import pet_pkg::*;

    localparam int RAM_TESTS      = 3;
    localparam int FRAME_CYCLES   = 32 * 8 + 40;   // SCK bits plus CS setup and bus wait
    localparam int NUM_FRAMES     = 3 * RAM_TESTS + 3;
    localparam int DECODE_CYCLES  = 448;
    localparam int TIMEOUT_CYCLES = 5 * (NUM_FRAMES * FRAME_CYCLES + DECODE_CYCLES);

    localparam wb_addr_t REG_CTL      = 18'h20000 | 18'(`PET_REG_CPU_CTL);
    localparam wb_addr_t REG_UNMAPPED = 18'h20005;

    logic      sys_clock_i;
    logic      sys_rstn_i;
    cpu_addr_t cpu_addr_i;
    logic      cpu_we_i;
    data_t     cpu_data_i = '0;   // Driven by the RAM model only
    logic      spi_cs_ni;
    logic      spi_sck_i;
    logic      spi_sd_i;

    logic      cpu_be_o;
    logic      cpu_clock_o;
    logic      cpu_reset_o;
    logic      cpu_ready_o;
    logic      cpu_addr_oe_o;
    data_t     cpu_data_o;
    logic      cpu_data_oe_o;
    ram_addr_t ram_addr_o;
    logic      ram_oe_o;
    logic      ram_we_o;
    logic      pia1_cs_o;
    logic      pia2_cs_o;
    logic      via_cs_o;
    logic      crtc_cs_o;
    logic      io_oe_o;
    logic      spi_sd_o;
    logic      spi_stall_o;

    data_t     ram_model [ram_addr_t];   // Sparse, holds written bytes only
    ram_addr_t exp_addr;
    data_t     exp_data;
    logic      spi_section;              // Bridge traffic expected
    int        we_pulses   = 0;
    int        oe_pulses   = 0;
    logic      we_prev     = 1'b0;
    logic      oe_prev     = 1'b0;
    int        cycle_count = 0;
    int        phase_model = 0;          // Expected phase within the CPU cycle

    pet_bus_top UUT (.*);

    always #2 sys_clock_i = ~sys_clock_i;

    task automatic report_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            report_failure($sformatf("%s is 0x%0h, expected 0x%0h", what, got, expected));
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge sys_clock_i);
        #1;
    endtask

    // Command byte, address high, address low, data
    function automatic logic [31:0] make_frame(input logic write, input wb_addr_t addr,
                                               input data_t data);
        return {write, 5'b0, addr, data};
    endfunction

    function automatic data_t read_ram(input ram_addr_t addr);
        if (ram_model.exists(addr)) return ram_model[addr];
        return addr[7:0] ^ addr[15:8] ^ {7'b0, addr[16]};   // Fill over the whole address
    endfunction

    // Half the picks land on the IO page, mostly on a chip select
    function automatic cpu_addr_t pick_cpu_addr();
        logic [31:0] r;
        logic [3:0]  nib;
        r = $urandom;
        if (r[0]) return cpu_addr_t'(r[31:16]);
        nib = (r[4] == 1'b0) ? (4'b0001 << r[3:2]) : r[11:8];
        return {8'hE8, nib, r[15:12]};
    endfunction

    // Mode 0, 8 system clocks per bit, returns the first byte seen on MISO
    task automatic spi_frame(input logic [31:0] frame, output data_t miso_byte);
        miso_byte = '0;
        while (spi_stall_o) wait_clocks(1);
        wait_clocks(4);                          // Reply byte loads into the shifter
        spi_cs_ni = 1'b0;
        wait_clocks(4);
        for (int i = 31; i >= 0; i--) begin
            spi_sck_i = 1'b0;
            spi_sd_i  = frame[i];
            wait_clocks(4);
            if (i >= 24) miso_byte[i - 24] = spi_sd_o;
            spi_sck_i = 1'b1;
            wait_clocks(4);
        end
        spi_sck_i = 1'b0;
        wait_clocks(4);
        spi_cs_ni = 1'b1;
        while (spi_stall_o) wait_clocks(1);      // Bus transfer finished
    endtask

    // RAM model, sampled mid cycle
    always @(negedge sys_clock_i) begin
        if (ram_we_o && !we_prev && !cpu_be_o) we_pulses++;
        if (ram_oe_o && !oe_prev && !cpu_be_o) oe_pulses++;
        if (ram_we_o && cpu_data_oe_o) ram_model[ram_addr_o] = cpu_data_o;
        we_prev = ram_we_o;
        oe_prev = ram_oe_o;
    end

    always @(posedge sys_clock_i) begin
        #1;
        if (ram_oe_o) cpu_data_i = read_ram(ram_addr_o);
    end

    // Phase 0 is the first clock after reset
    always @(posedge sys_clock_i) begin
        phase_model <= sys_rstn_i ? (phase_model + 1) % `PET_CPU_CYCLE : 0;
    end

    always @(posedge sys_clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    a_cpu_be_phase: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        cpu_be_o == (phase_model >= `PET_CPU_PHASE))
        else report_failure("CPU bus enable is not high in the second half of the cycle");

    a_cpu_clock_phase: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        cpu_clock_o == (phase_model >= `PET_CPU_PHASE))
        else report_failure("CPU clock is not high in the second half of the cycle");

    a_addr_oe: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        cpu_addr_oe_o == (phase_model < `PET_CPU_PHASE))
        else report_failure("Address output enable does not follow the bridge phase");

    a_bridge_window: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        (spi_section && (ram_oe_o || ram_we_o)) |-> (!cpu_be_o && ram_addr_o == exp_addr))
        else report_failure("Bridge RAM access outside its window or at a wrong address");

    a_bridge_wdata: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        (spi_section && ram_we_o) |-> (cpu_data_oe_o && cpu_data_o == exp_data))
        else report_failure("Bridge write data does not match the frame");

    a_pia1: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        pia1_cs_o == (cpu_be_o && cpu_addr_i[15:4] == 12'hE81))
        else report_failure("PIA1 select does not match the memory map");

    a_pia2: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        pia2_cs_o == (cpu_be_o && cpu_addr_i[15:4] == 12'hE82))
        else report_failure("PIA2 select does not match the memory map");

    a_via: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        via_cs_o == (cpu_be_o && cpu_addr_i[15:4] == 12'hE84))
        else report_failure("VIA select does not match the memory map");

    a_crtc: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        crtc_cs_o == (cpu_be_o && cpu_addr_i[15:4] == 12'hE88))
        else report_failure("CRTC select does not match the memory map");

    a_io_page: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        io_oe_o == (cpu_be_o && cpu_addr_i >= 16'hE800 && cpu_addr_i <= 16'hE8FF))
        else report_failure("IO enable does not match the E8 page");

    // ROM reads come from RAM, ROM writes are dropped
    a_cpu_ram_oe: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        cpu_be_o |-> (ram_oe_o == (!cpu_we_i && cpu_addr_i < 16'hE800)))
        else report_failure("RAM OE does not follow a CPU RAM or ROM read");

    a_cpu_ram_we: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        cpu_be_o |-> (ram_we_o == (cpu_we_i && cpu_addr_i < 16'h9000)))
        else report_failure("RAM WE does not follow a CPU write below 9000");

    a_io_excl: assert property (@(posedge sys_clock_i) disable iff (!sys_rstn_i)
        !(io_oe_o && (ram_oe_o || ram_we_o)))
        else report_failure("IO and RAM active together");

    initial begin
        ram_addr_t addr;
        data_t     data;
        data_t     miso;
        int        we_before;
        int        oe_before;

        void'($urandom(32'hb5b6));
        sys_clock_i = 1'b0;
        sys_rstn_i  = 1'b0;
        cpu_addr_i  = 16'hE800;   // IO page base, no chip select
        cpu_we_i    = 1'b0;
        spi_cs_ni   = 1'b1;
        spi_sck_i   = 1'b0;
        spi_sd_i    = 1'b0;
        spi_section = 1'b0;
        exp_addr    = '0;
        exp_data    = '0;

        repeat (4) @(posedge sys_clock_i);
        #1 sys_rstn_i = 1'b1;
        wait_clocks(1);

        check_value("cpu_reset_o after reset", int'(cpu_reset_o), 1);
        check_value("cpu_ready_o after reset", int'(cpu_ready_o), 0);
        check_value("ram_oe_o after reset", int'(ram_oe_o), 0);
        check_value("ram_we_o after reset", int'(ram_we_o), 0);
        check_value("spi_stall_o after reset", int'(spi_stall_o), 0);

        spi_section = 1'b1;
        for (int n = 0; n < RAM_TESTS; n++) begin
            addr      = ram_addr_t'($urandom);
            data      = data_t'($urandom);
            exp_addr  = addr;
            exp_data  = data;
            we_before = we_pulses;
            oe_before = oe_pulses;
            spi_frame(make_frame(1'b1, {1'b0, addr}, data), miso);
            check_value("Bridge write pulses", we_pulses - we_before, 1);
            check_value("Bridge read pulses during write", oe_pulses - oe_before, 0);
            check_value("RAM model byte", int'(read_ram(addr)), int'(data));
            spi_frame(make_frame(1'b0, {1'b0, addr}, '0), miso);
            check_value("Bridge read pulses", oe_pulses - oe_before, 1);
            // Read reply shifts out during the following frame
            spi_frame(make_frame(1'b0, REG_UNMAPPED, '0), miso);
            check_value("SPI read byte", int'(miso), int'(data));
        end

        spi_frame(make_frame(1'b1, REG_CTL, 8'h01), miso);   // Ready set, reset released
        check_value("cpu_ready_o after write", int'(cpu_ready_o), 1);
        check_value("cpu_reset_o after write", int'(cpu_reset_o), 0);
        spi_frame(make_frame(1'b0, REG_CTL, '0), miso);
        check_value("Unmapped register readback", int'(miso), 0);
        spi_frame(make_frame(1'b0, REG_UNMAPPED, '0), miso);
        check_value("Control register readback", int'(miso), 8'h01);
        spi_section = 1'b0;

        for (int n = 0; n < DECODE_CYCLES; n++) begin
            cpu_addr_i = pick_cpu_addr();
            cpu_we_i   = 1'($urandom);
            wait_clocks(1);
        end

        wait_clocks(2);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/pet_pkg.sv
verilog/wb_bus_if.sv
verilog/bus_timing.sv
verilog/spi_bridge.sv
verilog/ram_bridge.sv
verilog/register_file.sv
verilog/cpu_bus_decoder.sv
verilog/pet_bus_top.sv
bench/pet_bus_tb.sv

// ==== verilog/bus_timing.sv ====
`timescale 1ns/1ps
`include "pet_defs.svh"

module bus_timing (
    input  logic sys_clock_i,
    input  logic sys_rstn_i,
    output logic cpu_be_o,
    output logic cpu_clock_o,
    output logic grant_o
);
    localparam int PHASE_WIDTH = $clog2(`PET_CPU_CYCLE);

    logic [PHASE_WIDTH-1:0] phase_q;
    logic [PHASE_WIDTH-1:0] phase_next;
    logic                   cpu_half_q;   // Registered so the CPU clock pin is clean

    // Wraps at the end of each 1 MHz cycle
    assign phase_next = (phase_q == PHASE_WIDTH'(`PET_CPU_CYCLE - 1))
                      ? '0
                      : phase_q + 1'b1;

    always_ff @(posedge sys_clock_i or negedge sys_rstn_i) begin
        if (!sys_rstn_i) begin
            phase_q    <= '0;
            cpu_half_q <= 1'b0;
        end else begin
            phase_q    <= phase_next;
            cpu_half_q <= (phase_next >= PHASE_WIDTH'(`PET_CPU_PHASE));
        end
    end

    // PHI2 high while the 6502 owns the bus
    assign cpu_clock_o = cpu_half_q;
    assign cpu_be_o    = cpu_half_q;

    // Bridge may start accesses early in the cycle
    assign grant_o = (phase_q <= PHASE_WIDTH'(`PET_GRANT_LAST));

    a_grant_vs_cpu: assert property (
        @(posedge sys_clock_i) disable iff (!sys_rstn_i)
        !(grant_o && cpu_be_o)
    ) else $error("Bridge grant overlaps CPU bus phase");

endmodule

// ==== verilog/cpu_bus_decoder.sv ====
`timescale 1ns/1ps

module cpu_bus_decoder (
    input  logic               cpu_be_i,
    input  logic               cpu_clock_i,
    input  logic               cpu_we_i,
    input  pet_pkg::cpu_addr_t cpu_addr_i,
    input  pet_pkg::ram_addr_t ctl_addr_i,
    input  logic               ctl_oe_i,
    input  logic               ctl_we_i,
    output pet_pkg::ram_addr_t ram_addr_o,
    output logic               ram_oe_o,
    output logic               ram_we_o,
    output logic               pia1_cs_o,
    output logic               pia2_cs_o,
    output logic               via_cs_o,
    output logic               crtc_cs_o,
    output logic               io_oe_o,
    output logic               cpu_addr_oe_o
);
    logic ram_en;    // 0000-8FFF including video RAM
    logic rom_en;    // 9000-E7FF
    logic io_page;   // E800-E8FF
    logic cpu_rd;
    logic cpu_wr;

    assign ram_en  = (cpu_addr_i[15:12] < 4'h9);
    assign rom_en  = !ram_en && (cpu_addr_i < 16'hE800);
    assign io_page = (cpu_addr_i[15:8] == 8'hE8);

    assign cpu_rd = cpu_be_i && !cpu_we_i;
    assign cpu_wr = cpu_be_i && cpu_we_i && cpu_clock_i;

    // ROM lives in RAM but is write protected
    assign ram_oe_o = cpu_be_i ? (cpu_rd && (ram_en || rom_en)) : ctl_oe_i;
    assign ram_we_o = cpu_be_i ? (cpu_wr && ram_en) : ctl_we_i;

    assign ram_addr_o    = cpu_be_i ? {1'b0, cpu_addr_i} : ctl_addr_i;
    assign cpu_addr_oe_o = !cpu_be_i;   // Bridge drives address lines

    // Peripherals each take 16 bytes of the IO page
    assign io_oe_o   = cpu_be_i && io_page;
    assign pia1_cs_o = io_oe_o && (cpu_addr_i[7:4] == 4'h1);
    assign pia2_cs_o = io_oe_o && (cpu_addr_i[7:4] == 4'h2);
    assign via_cs_o  = io_oe_o && (cpu_addr_i[7:4] == 4'h4);
    assign crtc_cs_o = io_oe_o && (cpu_addr_i[7:4] == 4'h8);

    // Sampled at the end of the CPU phase
    a_io_ram_oe: assert property (@(negedge cpu_clock_i) !(io_oe_o && ram_oe_o))
        else $error("IO and RAM OE both drive the bus");

    a_io_ram_we: assert property (@(negedge cpu_clock_i) !(io_oe_o && ram_we_o))
        else $error("IO and RAM WE active together");

    // Sampled at the end of the bridge phase
    a_io_needs_be: assert property (@(posedge cpu_clock_i) !io_oe_o || cpu_be_i)
        else $error("IO active while bridge owns the bus");

endmodule

// ==== verilog/pet_bus_top.sv ====
`timescale 1ns/1ps

module pet_bus_top (
    input  logic               sys_clock_i,
    input  logic               sys_rstn_i,
    input  pet_pkg::cpu_addr_t cpu_addr_i,
    input  logic               cpu_we_i,
    input  pet_pkg::data_t     cpu_data_i,   // Shared data bus, also RAM read data
    input  logic               spi_cs_ni,
    input  logic               spi_sck_i,
    input  logic               spi_sd_i,
    output logic               cpu_be_o,
    output logic               cpu_clock_o,
    output logic               cpu_reset_o,
    output logic               cpu_ready_o,
    output logic               cpu_addr_oe_o,
    output pet_pkg::data_t     cpu_data_o,
    output logic               cpu_data_oe_o,
    output pet_pkg::ram_addr_t ram_addr_o,
    output logic               ram_oe_o,
    output logic               ram_we_o,
    output logic               pia1_cs_o,
    output logic               pia2_cs_o,
    output logic               via_cs_o,
    output logic               crtc_cs_o,
    output logic               io_oe_o,
    output logic               spi_sd_o,
    output logic               spi_stall_o
);
    import pet_pkg::*;

    ram_addr_t ctl_addr;   // Bridge RAM request
    logic      ctl_oe;
    logic      ctl_we;
    logic      grant;

    wb_bus_if bus ();

    bus_timing u_timing (
        .sys_clock_i (sys_clock_i),
        .sys_rstn_i  (sys_rstn_i),
        .cpu_be_o    (cpu_be_o),
        .cpu_clock_o (cpu_clock_o),
        .grant_o     (grant)
    );

    spi_bridge u_spi (
        .sys_clock_i (sys_clock_i),
        .sys_rstn_i  (sys_rstn_i),
        .spi_cs_ni   (spi_cs_ni),
        .spi_sck_i   (spi_sck_i),
        .spi_sd_i    (spi_sd_i),
        .spi_sd_o    (spi_sd_o),
        .spi_stall_o (spi_stall_o),
        .bus         (bus.controller)
    );

    ram_bridge u_ram (
        .sys_clock_i   (sys_clock_i),
        .sys_rstn_i    (sys_rstn_i),
        .grant_i       (grant),
        .ram_data_i    (cpu_data_i),
        .ram_addr_o    (ctl_addr),
        .ram_oe_o      (ctl_oe),
        .ram_we_o      (ctl_we),
        .ram_data_o    (cpu_data_o),
        .ram_data_oe_o (cpu_data_oe_o),
        .bus           (bus.ram_side)
    );

    register_file u_regs (
        .sys_clock_i (sys_clock_i),
        .sys_rstn_i  (sys_rstn_i),
        .cpu_reset_o (cpu_reset_o),
        .cpu_ready_o (cpu_ready_o),
        .bus         (bus.reg_side)
    );

    cpu_bus_decoder u_decode (
        .cpu_be_i      (cpu_be_o),
        .cpu_clock_i   (cpu_clock_o),
        .cpu_we_i      (cpu_we_i),
        .cpu_addr_i    (cpu_addr_i),
        .ctl_addr_i    (ctl_addr),
        .ctl_oe_i      (ctl_oe),
        .ctl_we_i      (ctl_we),
        .ram_addr_o    (ram_addr_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .pia1_cs_o     (pia1_cs_o),
        .pia2_cs_o     (pia2_cs_o),
        .via_cs_o      (via_cs_o),
        .crtc_cs_o     (crtc_cs_o),
        .io_oe_o       (io_oe_o),
        .cpu_addr_oe_o (cpu_addr_oe_o)
    );

endmodule

// ==== verilog/pet_defs.svh ====
`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// Bus widths
`define PET_DATA_WIDTH     8
`define PET_CPU_ADDR_WIDTH 16
`define PET_RAM_ADDR_WIDTH 17
`define PET_WB_ADDR_WIDTH  18   // Top bit selects the register file

// System clocks per 1 MHz CPU cycle
`define PET_CPU_CYCLE      16
`define PET_CPU_PHASE      8    // CPU owns the bus from here to end of cycle
`define PET_GRANT_LAST     4    // Last phase a bridge access may start

// Register map
`define PET_REG_CPU_CTL    0

`endif

// ==== verilog/pet_pkg.sv ====
`include "pet_defs.svh"

package pet_pkg;

    // One data byte on any bus
    typedef logic [`PET_DATA_WIDTH-1:0] data_t;

    // 6502 address
    typedef logic [`PET_CPU_ADDR_WIDTH-1:0] cpu_addr_t;

    // Board RAM address, 128 KiB
    typedef logic [`PET_RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // Internal bus address
    typedef logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_t;

endpackage

// ==== verilog/ram_bridge.sv ====
`timescale 1ns/1ps
`include "pet_defs.svh"

module ram_bridge (
    input  logic              sys_clock_i,
    input  logic              sys_rstn_i,
    input  logic              grant_i,
    input  pet_pkg::data_t    ram_data_i,
    output pet_pkg::ram_addr_t ram_addr_o,
    output logic              ram_oe_o,
    output logic              ram_we_o,
    output pet_pkg::data_t    ram_data_o,
    output logic              ram_data_oe_o,
    wb_bus_if.ram_side        bus
);
    import pet_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_grant,
        st_access,    // Second RAM cycle
        st_finish     // Ack cycle
    } state_t;

    state_t    state_q;
    ram_addr_t addr_q;
    data_t     wdata_q;
    data_t     rdata_q;
    logic      we_q;
    logic      drive;

    always_ff @(posedge sys_clock_i or negedge sys_rstn_i) begin
        if (!sys_rstn_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (bus.strobe && !bus.addr[`PET_WB_ADDR_WIDTH-1]) begin
                    state_q <= st_wait_grant;
                end
                st_wait_grant: if (grant_i) state_q <= st_access;   // First RAM cycle
                st_access:     state_q <= st_finish;
                default:       state_q <= st_idle;
            endcase
        end
    end

    // Request and read data
    always_ff @(posedge sys_clock_i) begin
        if (state_q == st_idle && bus.strobe) begin
            addr_q  <= bus.addr[`PET_RAM_ADDR_WIDTH-1:0];
            wdata_q <= bus.wdata;
            we_q    <= bus.we;
        end
        if (state_q == st_access) rdata_q <= ram_data_i;
    end

    // Two RAM cycles starting in the first granted phase
    assign drive = (state_q == st_wait_grant && grant_i) || state_q == st_access;

    assign ram_addr_o    = addr_q;
    assign ram_oe_o      = drive && !we_q;
    assign ram_we_o      = drive && we_q;
    assign ram_data_o    = wdata_q;
    assign ram_data_oe_o = drive && we_q;

    assign bus.ram_stall = (state_q != st_idle);
    assign bus.ram_ack   = (state_q == st_finish);
    assign bus.ram_rdata = rdata_q;

    a_oe_we_excl: assert property (
        @(posedge sys_clock_i) disable iff (!sys_rstn_i)
        !(ram_oe_o && ram_we_o)
    ) else $error("RAM OE and WE both high");

    a_in_window: assert property (
        @(posedge sys_clock_i) disable iff (!sys_rstn_i)
        (ram_oe_o || ram_we_o) |-> (grant_i || $past(ram_oe_o || ram_we_o))
    ) else $error("RAM access started outside grant window");

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`include "pet_defs.svh"

module register_file (
    input  logic       sys_clock_i,
    input  logic       sys_rstn_i,
    output logic       cpu_reset_o,
    output logic       cpu_ready_o,
    wb_bus_if.reg_side bus
);
    import pet_pkg::*;

    localparam int REG_BITS = `PET_WB_ADDR_WIDTH - 1;

    logic  hit;
    logic  ctl_sel;
    logic  ack_q;
    data_t rdata_q;

    assign hit     = bus.strobe && bus.addr[`PET_WB_ADDR_WIDTH-1];
    assign ctl_sel = (bus.addr[REG_BITS-1:0] == REG_BITS'(`PET_REG_CPU_CTL));

    always_ff @(posedge sys_clock_i or negedge sys_rstn_i) begin
        if (!sys_rstn_i) begin
            ack_q       <= 1'b0;
            cpu_ready_o <= 1'b0;
            cpu_reset_o <= 1'b1;   // Hold CPU until the MCU releases it
        end else begin
            ack_q <= hit;
            if (hit && bus.we && ctl_sel) begin
                cpu_ready_o <= bus.wdata[0];
                cpu_reset_o <= bus.wdata[1];
            end
        end
    end

    // Unmapped registers read as zero
    always_ff @(posedge sys_clock_i) begin
        if (hit) rdata_q <= ctl_sel ? data_t'({cpu_reset_o, cpu_ready_o}) : '0;
    end

    assign bus.reg_ack   = ack_q;
    assign bus.reg_rdata = rdata_q;

endmodule

// ==== verilog/spi_bridge.sv ====
`timescale 1ns/1ps
`include "pet_defs.svh"

module spi_bridge (
    input  logic         sys_clock_i,
    input  logic         sys_rstn_i,
    input  logic         spi_cs_ni,
    input  logic         spi_sck_i,
    input  logic         spi_sd_i,
    output logic         spi_sd_o,
    output logic         spi_stall_o,
    wb_bus_if.controller bus
);
    import pet_pkg::*;

    localparam int FRAME_BITS = 32;

    logic [2:0] sck_sync_q;   // Extra stage for edge detect
    logic [1:0] cs_sync_q;
    logic [1:0] sd_sync_q;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_active;

    logic [FRAME_BITS-1:0]         frame_q;
    logic [$clog2(FRAME_BITS)-1:0] bit_count_q;
    logic                          frame_we;
    logic                          req_q;    // Frame complete, strobe not yet issued
    logic                          busy_q;   // Strobe issued, waiting for ack
    data_t                         rdata_q;
    data_t                         tx_q;

    // Bring the SPI pins into the system clock domain
    always_ff @(posedge sys_clock_i or negedge sys_rstn_i) begin
        if (!sys_rstn_i) begin
            sck_sync_q <= '0;
            cs_sync_q  <= '1;
            sd_sync_q  <= '0;
        end else begin
            sck_sync_q <= {sck_sync_q[1:0], spi_sck_i};
            cs_sync_q  <= {cs_sync_q[0], spi_cs_ni};
            sd_sync_q  <= {sd_sync_q[0], spi_sd_i};
        end
    end

    assign sck_rise  = sck_sync_q[1] && !sck_sync_q[2];
    assign sck_fall  = !sck_sync_q[1] && sck_sync_q[2];
    assign cs_active = !cs_sync_q[1];

    // Mode 0 samples MOSI on the rising edge, MSB first
    always_ff @(posedge sys_clock_i) begin
        if (cs_active && sck_rise) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], sd_sync_q[1]};
        end
    end

    always_ff @(posedge sys_clock_i or negedge sys_rstn_i) begin
        if (!sys_rstn_i) begin
            bit_count_q <= '0;
            req_q       <= 1'b0;
            busy_q      <= 1'b0;
            rdata_q     <= '0;
        end else begin
            if (!cs_active) begin
                bit_count_q <= '0;   // Resync frame on CS high
            end else if (sck_rise) begin
                bit_count_q <= bit_count_q + 1'b1;
            end

            if (cs_active && sck_rise && bit_count_q == '1) begin
                req_q <= 1'b1;
            end else if (bus.strobe) begin
                req_q <= 1'b0;
            end

            if (bus.strobe) begin
                busy_q <= 1'b1;
            end else if (bus.ack) begin
                busy_q <= 1'b0;
            end

            // Keep the byte for the next frame's reply
            if (busy_q && bus.ack && !frame_we) begin
                rdata_q <= bus.rdata;
            end
        end
    end

    // MISO shifts on the falling edge and idles loaded with the last read byte
    always_ff @(posedge sys_clock_i) begin
        if (!cs_active) begin
            tx_q <= rdata_q;
        end else if (sck_fall) begin
            tx_q <= {tx_q[`PET_DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_q[`PET_DATA_WIDTH-1];

    // Frame is command, address high, address low, data
    assign frame_we   = frame_q[FRAME_BITS-1];
    assign bus.we     = frame_we;
    assign bus.addr   = frame_q[`PET_WB_ADDR_WIDTH+`PET_DATA_WIDTH-1:`PET_DATA_WIDTH];
    assign bus.wdata  = frame_q[`PET_DATA_WIDTH-1:0];
    assign bus.strobe = req_q && !bus.stall;

    assign spi_stall_o = req_q || busy_q;

    a_one_outstanding: assert property (
        @(posedge sys_clock_i) disable iff (!sys_rstn_i)
        bus.strobe |-> !busy_q
    ) else $error("Strobe issued before previous ack");

endmodule

// ==== verilog/wb_bus_if.sv ====
`timescale 1ns/1ps

interface wb_bus_if;
    import pet_pkg::*;

    // Controller side
    wb_addr_t addr;
    data_t    wdata;
    logic     we;
    logic     strobe;
    logic     stall;
    logic     ack;
    data_t    rdata;

    // Per peripheral returns
    logic     ram_ack;
    data_t    ram_rdata;
    logic     ram_stall;
    logic     reg_ack;
    data_t    reg_rdata;

    // Only one peripheral answers a given strobe
    assign ack   = ram_ack | reg_ack;
    assign rdata = reg_ack ? reg_rdata : ram_rdata;
    assign stall = ram_stall;   // Register file never stalls

    modport controller (output addr, wdata, we, strobe, input stall, ack, rdata);

    modport ram_side (input addr, wdata, we, strobe, output ram_ack, ram_rdata, ram_stall);

    modport reg_side (input addr, wdata, we, strobe, output reg_ack, reg_rdata);

endinterface
